// File: list.f
+incdir+.
rvIsaPkg.sv
rvPipePkg.sv
rvDecoder.sv
rvOperandStage.sv
rvExecutor.sv
rvExecSlice.sv
tbRvExecSlice.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tbRvExecSlice -o simTb
simOut=$(./obj_dir/simTb)
echo "$simOut"
if echo "$simOut" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: rvDecoder.sv
/* Instruction decoder
   control unit and immediate generator, one registered stage */
`timescale 1ns/1ps

module rvDecoder (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instValid,
    input  logic [31:0]         instWord,
    input  logic [31:0]         pc,
    input  logic [31:0]         rs1Data,
    input  logic [31:0]         rs2Data,
    output logic                decValid,
    output rvPipePkg::decodedOpT dec
);

    rvPipePkg::decodedOpT decNext;
    rvIsaPkg::immKindE    immKind;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;

    assign opcode = instWord[6:0];
    assign funct3 = instWord[14:12];
    assign funct7 = instWord[31:25];

    // control unit
    always_comb begin
        decNext          = '0;
        decNext.pc       = pc;
        decNext.rs1Data  = rs1Data;
        decNext.rs2Data  = rs2Data;
        decNext.opcode   = opcode;
        decNext.funct3   = funct3;
        decNext.funct7   = funct7;
        decNext.rd       = instWord[11:7];
        decNext.wbSel    = rvPipePkg::wbAlu;
        decNext.memSize  = rvIsaPkg::sizeByte;
        immKind          = rvIsaPkg::immNone;
        case (opcode)
            rvIsaPkg::opCompute: begin
                decNext.regWrite = 1'b1;
                if (funct7 != rvIsaPkg::funct7Base &&
                    !(funct7 == rvIsaPkg::funct7Alt &&
                      (funct3 == rvIsaPkg::f3AddSub || funct3 == rvIsaPkg::f3SrlSra)))
                    decNext.illegal = 1'b1; // includes the mul/div space
            end
            rvIsaPkg::opICompute: begin
                decNext.regWrite = 1'b1;
                decNext.bSelImm  = 1'b1;
                if (funct3 == rvIsaPkg::f3Sll || funct3 == rvIsaPkg::f3SrlSra) begin
                    immKind = rvIsaPkg::immShiftI;
                    if (funct7 != rvIsaPkg::funct7Base &&
                        !(funct3 == rvIsaPkg::f3SrlSra && funct7 == rvIsaPkg::funct7Alt))
                        decNext.illegal = 1'b1;
                end else begin
                    immKind = rvIsaPkg::immI;
                end
            end
            rvIsaPkg::opLoad: begin
                immKind          = rvIsaPkg::immI;
                decNext.regWrite = 1'b1;
                decNext.bSelImm  = 1'b1;
                decNext.memRead  = 1'b1;
                decNext.wbSel    = rvPipePkg::wbMem;
                case (funct3)
                    rvIsaPkg::f3Byte, rvIsaPkg::f3ByteU: decNext.memSize = rvIsaPkg::sizeByte;
                    rvIsaPkg::f3Half, rvIsaPkg::f3HalfU: decNext.memSize = rvIsaPkg::sizeHalf;
                    rvIsaPkg::f3Word:                    decNext.memSize = rvIsaPkg::sizeWord;
                    default:                             decNext.illegal = 1'b1;
                endcase
            end
            rvIsaPkg::opStore: begin
                immKind          = rvIsaPkg::immS;
                decNext.bSelImm  = 1'b1;
                decNext.memWrite = 1'b1;
                case (funct3)
                    rvIsaPkg::f3Byte: decNext.memSize = rvIsaPkg::sizeByte;
                    rvIsaPkg::f3Half: decNext.memSize = rvIsaPkg::sizeHalf;
                    rvIsaPkg::f3Word: decNext.memSize = rvIsaPkg::sizeWord;
                    default:          decNext.illegal = 1'b1;
                endcase
            end
            rvIsaPkg::opBranch: begin
                immKind         = rvIsaPkg::immB;
                decNext.aSelPc  = 1'b1; // target = pc + imm
                decNext.bSelImm = 1'b1;
                decNext.illegal = (funct3 == 3'b010 || funct3 == 3'b011);
            end
            rvIsaPkg::opJal: begin
                immKind          = rvIsaPkg::immJ;
                decNext.regWrite = 1'b1;
                decNext.aSelPc   = 1'b1;
                decNext.bSelImm  = 1'b1;
                decNext.wbSel    = rvPipePkg::wbPc4;
            end
            rvIsaPkg::opJalr: begin
                immKind          = rvIsaPkg::immI;
                decNext.regWrite = 1'b1;
                decNext.bSelImm  = 1'b1;
                decNext.wbSel    = rvPipePkg::wbPc4;
            end
            rvIsaPkg::opLui: begin
                immKind          = rvIsaPkg::immU;
                decNext.regWrite = 1'b1;
                decNext.wbSel    = rvPipePkg::wbImm;
            end
            rvIsaPkg::opAuipc: begin
                immKind          = rvIsaPkg::immU;
                decNext.regWrite = 1'b1;
                decNext.aSelPc   = 1'b1;
                decNext.bSelImm  = 1'b1;
            end
            default: decNext.illegal = 1'b1; // unknown opcode
        endcase

        // immediate generator
        case (immKind)
            rvIsaPkg::immI:      decNext.imm = {{20{instWord[31]}}, instWord[31:20]};
            rvIsaPkg::immS:      decNext.imm = {{20{instWord[31]}}, instWord[31:25],
                                                instWord[11:7]};
            rvIsaPkg::immB:      decNext.imm = {{19{instWord[31]}}, instWord[31], instWord[7],
                                                instWord[30:25], instWord[11:8], 1'b0};
            rvIsaPkg::immU:      decNext.imm = {instWord[31:12], 12'b0};
            rvIsaPkg::immJ:      decNext.imm = {{11{instWord[31]}}, instWord[31],
                                                instWord[19:12], instWord[20],
                                                instWord[30:21], 1'b0};
            rvIsaPkg::immShiftI: decNext.imm = {27'b0, instWord[24:20]}; // shamt only
            default:             decNext.imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
            dec      <= '0;
        end else begin
            decValid <= instValid;
            if (instValid)
                dec <= decNext;
        end
    end

    // valid strobe must stay defined once out of reset
    assert property (@(posedge clk) disable iff (!rstN) !$isunknown(decValid));

endmodule

// File: rvExecSlice.sv
/* RV32I execute slice top
   decoder, operand stage and executor in a three cycle chain */
`timescale 1ns/1ps

module rvExecSlice (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  instValid,
    input  logic [31:0]           instWord,
    input  logic [31:0]           pc,
    input  logic [31:0]           rs1Data,
    input  logic [31:0]           rs2Data,
    output logic                  resValid,
    output rvPipePkg::execResultT result
);

    logic                 decValid;
    rvPipePkg::decodedOpT dec;
    logic                 opValid;
    rvPipePkg::operandOpT op;

    rvDecoder u_decoder (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instWord  (instWord),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .decValid  (decValid),
        .dec       (dec)
    );

    rvOperandStage u_operand (
        .clk      (clk),
        .rstN     (rstN),
        .decValid (decValid),
        .dec      (dec),
        .opValid  (opValid),
        .op       (op)
    );

    rvExecutor u_executor (
        .clk      (clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .op       (op),
        .resValid (resValid),
        .result   (result)
    );

endmodule

// File: rvExecutor.sv
/* Executor
   ALU, branch compare, next pc and alignment halts, registered result */
`timescale 1ns/1ps

module rvExecutor (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  opValid,
    input  rvPipePkg::operandOpT  op,
    output logic                  resValid,
    output rvPipePkg::execResultT result
);

    rvPipePkg::execResultT resNext;
    logic [31:0] aluSum;
    logic [31:0] aluOut;
    logic [31:0] pcPlus4;
    logic [31:0] target;
    logic [4:0]  shamt;
    logic        isAlu;
    logic        isAlt;
    logic        cond;
    logic        taken;
    logic        sizeHalt;
    logic        pcHalt;
    logic        halt;

    assign aluSum  = op.opA + op.opB;
    assign pcPlus4 = op.pc + 32'd4;
    assign shamt   = op.opB[4:0];
    assign isAlu   = (op.opcode == rvIsaPkg::opCompute) || (op.opcode == rvIsaPkg::opICompute);
    assign isAlt   = (op.funct7 == rvIsaPkg::funct7Alt);

    // anything that is not compute takes the add path
    always_comb begin
        aluOut = aluSum;
        if (isAlu) begin
            case (op.funct3)
                rvIsaPkg::f3AddSub:
                    if (op.opcode == rvIsaPkg::opCompute && isAlt)
                        aluOut = op.opA - op.opB;
                rvIsaPkg::f3Sll:    aluOut = op.opA << shamt;
                rvIsaPkg::f3Slt:    aluOut = {31'b0, $signed(op.opA) < $signed(op.opB)};
                rvIsaPkg::f3Sltu:   aluOut = {31'b0, op.opA < op.opB};
                rvIsaPkg::f3Xor:    aluOut = op.opA ^ op.opB;
                rvIsaPkg::f3SrlSra: aluOut = isAlt ? 32'($signed(op.opA) >>> shamt)
                                                   : op.opA >> shamt;
                rvIsaPkg::f3Or:     aluOut = op.opA | op.opB;
                rvIsaPkg::f3And:    aluOut = op.opA & op.opB;
                default:            aluOut = aluSum;
            endcase
        end
    end

    // branch compare on the raw register values
    always_comb begin
        case (op.funct3)
            rvIsaPkg::f3Beq:  cond = (op.rs1Data == op.rs2Data);
            rvIsaPkg::f3Bne:  cond = (op.rs1Data != op.rs2Data);
            rvIsaPkg::f3Blt:  cond = ($signed(op.rs1Data) < $signed(op.rs2Data));
            rvIsaPkg::f3Bge:  cond = ($signed(op.rs1Data) >= $signed(op.rs2Data));
            rvIsaPkg::f3Bltu: cond = (op.rs1Data < op.rs2Data);
            rvIsaPkg::f3Bgeu: cond = (op.rs1Data >= op.rs2Data);
            default:          cond = 1'b0;
        endcase
    end

    assign taken = (op.opcode == rvIsaPkg::opBranch && cond) ||
                   op.opcode == rvIsaPkg::opJal || op.opcode == rvIsaPkg::opJalr;
    assign target = (op.opcode == rvIsaPkg::opJalr) ? {aluSum[31:1], 1'b0} : aluSum;

    // size check and pc alignment
    assign sizeHalt = (op.memRead || op.memWrite) &&
                      ((op.memSize == rvIsaPkg::sizeHalf && aluOut[0]) ||
                       (op.memSize == rvIsaPkg::sizeWord && aluOut[1:0] != 2'b00));
    assign pcHalt   = taken && (target[1:0] != 2'b00);
    assign halt     = op.illegal || sizeHalt || pcHalt;

    always_comb begin
        resNext             = '0;
        resNext.rd          = op.rd;
        resNext.regWrite    = op.regWrite && !halt; // no write from a halted op
        resNext.memRead     = op.memRead;
        resNext.memWrite    = op.memWrite;
        resNext.memAddr     = aluOut;
        resNext.memSize     = op.memSize;
        resNext.branchTaken = taken;
        resNext.nextPc      = taken ? target : pcPlus4;
        resNext.halt        = halt;
        case (op.wbSel)
            rvPipePkg::wbAlu: resNext.wbValue = aluOut;
            rvPipePkg::wbPc4: resNext.wbValue = pcPlus4;  // link value
            rvPipePkg::wbImm: resNext.wbValue = op.imm;
            default:          resNext.wbValue = '0;       // load data not modelled
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
            result   <= '0;
        end else begin
            resValid <= opValid;
            if (opValid)
                result <= resNext;
        end
    end

    // decoder never marks an op as both load and store
    assert property (@(posedge clk) disable iff (!rstN)
        resValid |-> !(result.memRead && result.memWrite));

endmodule

// File: rvIsaPkg.sv
/* RV32I encoding constants
   opcodes, funct fields, immediate formats and memory access sizes */
package rvIsaPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // major opcodes
    localparam logic [6:0] opCompute  = 7'b0110011;
    localparam logic [6:0] opICompute = 7'b0010011;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam logic [6:0] opStore    = 7'b0100011;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opLui      = 7'b0110111;
    localparam logic [6:0] opAuipc    = 7'b0010111;

    // funct7 variants
    localparam logic [6:0] funct7Base = 7'h00;
    localparam logic [6:0] funct7Alt  = 7'h20; // sub, sra, srai

    // alu funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // load and store funct3
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100; // load only
    localparam logic [2:0] f3HalfU = 3'b101; // load only

    typedef enum logic [2:0] {
        immNone   = 3'b000,
        immI      = 3'b001,
        immS      = 3'b010,
        immB      = 3'b011,
        immU      = 3'b100,
        immJ      = 3'b101,
        immShiftI = 3'b110
    } immKindE;

    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } memSizeE;

endpackage

// File: rvOperandStage.sv
/* Operand stage
   picks ALU operands from registers, pc and immediate, registered */
`timescale 1ns/1ps

module rvOperandStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 decValid,
    input  rvPipePkg::decodedOpT dec,
    output logic                 opValid,
    output rvPipePkg::operandOpT op
);

    rvPipePkg::operandOpT opNext;

    always_comb begin
        opNext          = '0;
        opNext.pc       = dec.pc;
        opNext.rs1Data  = dec.rs1Data;
        opNext.rs2Data  = dec.rs2Data;
        opNext.imm      = dec.imm;
        opNext.opA      = dec.aSelPc ? dec.pc : dec.rs1Data;
        opNext.opB      = dec.bSelImm ? dec.imm : dec.rs2Data;
        opNext.opcode   = dec.opcode;
        opNext.funct3   = dec.funct3;
        opNext.funct7   = dec.funct7;
        opNext.rd       = dec.rd;
        opNext.regWrite = dec.regWrite;
        opNext.wbSel    = dec.wbSel;
        opNext.memRead  = dec.memRead;
        opNext.memWrite = dec.memWrite;
        opNext.memSize  = dec.memSize;
        opNext.illegal  = dec.illegal;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opValid <= 1'b0;
            op      <= '0;
        end else begin
            opValid <= decValid;
            if (decValid)
                op <= opNext;
        end
    end

    // pc as operand A always comes with an immediate as operand B
    assert property (@(posedge clk) disable iff (!rstN)
        decValid |-> (!dec.aSelPc || dec.bSelImm));

endmodule

// File: rvPipePkg.sv
/* Pipeline payload types
   structs passed from decoder to operand stage to executor */
package rvPipePkg;

    typedef enum logic [1:0] {
        wbAlu = 2'b00,
        wbMem = 2'b01,
        wbPc4 = 2'b10,
        wbImm = 2'b11
    } wbSelE;

    typedef struct packed {
        logic [rvIsaPkg::xlen-1:0]     pc;
        logic [rvIsaPkg::xlen-1:0]     rs1Data;
        logic [rvIsaPkg::xlen-1:0]     rs2Data;
        logic [rvIsaPkg::xlen-1:0]     imm;
        logic [6:0]                    opcode;
        logic [2:0]                    funct3;
        logic [6:0]                    funct7;
        logic [rvIsaPkg::regAddrW-1:0] rd;
        logic                          regWrite;
        logic                          aSelPc;  // opA from pc
        logic                          bSelImm; // opB from imm
        wbSelE                         wbSel;
        logic                          memRead;
        logic                          memWrite;
        rvIsaPkg::memSizeE             memSize;
        logic                          illegal;
    } decodedOpT;

    typedef struct packed {
        logic [rvIsaPkg::xlen-1:0]     pc;
        logic [rvIsaPkg::xlen-1:0]     rs1Data; // branch compare
        logic [rvIsaPkg::xlen-1:0]     rs2Data;
        logic [rvIsaPkg::xlen-1:0]     imm;
        logic [rvIsaPkg::xlen-1:0]     opA;
        logic [rvIsaPkg::xlen-1:0]     opB;
        logic [6:0]                    opcode;
        logic [2:0]                    funct3;
        logic [6:0]                    funct7;
        logic [rvIsaPkg::regAddrW-1:0] rd;
        logic                          regWrite;
        wbSelE                         wbSel;
        logic                          memRead;
        logic                          memWrite;
        rvIsaPkg::memSizeE             memSize;
        logic                          illegal;
    } operandOpT;

    typedef struct packed {
        logic [rvIsaPkg::regAddrW-1:0] rd;
        logic                          regWrite;
        logic [rvIsaPkg::xlen-1:0]     wbValue;
        logic                          memRead;
        logic                          memWrite;
        logic [rvIsaPkg::xlen-1:0]     memAddr;
        rvIsaPkg::memSizeE             memSize;
        logic                          branchTaken;
        logic [rvIsaPkg::xlen-1:0]     nextPc;
        logic                          halt;
    } execResultT;

endpackage

// File: tbRvModel.svh
/* Reference model for the RV32I execute slice
   expected result of one instruction from its word, pc and register values */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// integer op by funct3 where alt picks sub and sra
function automatic logic [31:0] aluRef(input logic [31:0] a, input logic [31:0] b,
                                       input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    aluRef = alt ? a - b : a + b;
        3'd1:    aluRef = a << b[4:0];
        3'd2:    aluRef = {31'd0, $signed(a) < $signed(b)};
        3'd3:    aluRef = {31'd0, a < b};
        3'd4:    aluRef = a ^ b;
        3'd5:    aluRef = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    aluRef = a | b;
        default: aluRef = a & b;
    endcase
endfunction

function automatic rvPipePkg::execResultT rvExpect(input logic [31:0] inst,
                                                   input logic [31:0] pcIn,
                                                   input logic [31:0] r1,
                                                   input logic [31:0] r2);
    rvPipePkg::execResultT r;
    logic [2:0]  f3;
    logic        alt;
    logic        bad;
    logic        wrt;
    logic        taken;
    logic        misaligned;
    logic [31:0] alu;
    logic [31:0] target;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    f3    = inst[14:12];
    alt   = (inst[31:25] == 7'h20);
    immI  = {{20{inst[31]}}, inst[31:20]};
    immS  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    immB  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    immJ  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    r     = '0;
    r.rd  = inst[11:7];
    bad   = 1'b0;
    wrt   = 1'b1;
    taken = 1'b0;
    alu   = r1 + r2; // formats without an immediate add both registers
    case (inst[6:0])
        rvIsaPkg::opCompute: begin
            bad = !(inst[31:25] == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
            alu = aluRef(r1, r2, f3, alt);
        end
        rvIsaPkg::opICompute: begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                bad = !(inst[31:25] == 7'h00 || (alt && f3 == 3'd5));
                alu = aluRef(r1, {27'd0, inst[24:20]}, f3, alt);
            end else begin
                alu = aluRef(r1, immI, f3, 1'b0);
            end
        end
        rvIsaPkg::opLoad: begin
            alu       = r1 + immI;
            r.memRead = 1'b1;
            bad       = (f3 == 3'd3 || f3 > 3'd5);
            if (f3 == 3'd1 || f3 == 3'd5)
                r.memSize = rvIsaPkg::sizeHalf;
            else if (f3 == 3'd2)
                r.memSize = rvIsaPkg::sizeWord;
        end
        rvIsaPkg::opStore: begin
            alu        = r1 + immS;
            wrt        = 1'b0;
            r.memWrite = 1'b1;
            bad        = (f3 > 3'd2);
            if (f3 == 3'd1)
                r.memSize = rvIsaPkg::sizeHalf;
            else if (f3 == 3'd2)
                r.memSize = rvIsaPkg::sizeWord;
        end
        rvIsaPkg::opBranch: begin
            alu = pcIn + immB;
            wrt = 1'b0;
            bad = (f3 == 3'd2 || f3 == 3'd3);
            case (f3)
                3'd0:    taken = (r1 == r2);
                3'd1:    taken = (r1 != r2);
                3'd4:    taken = ($signed(r1) < $signed(r2));
                3'd5:    taken = ($signed(r1) >= $signed(r2));
                3'd6:    taken = (r1 < r2);
                3'd7:    taken = (r1 >= r2);
                default: taken = 1'b0;
            endcase
        end
        rvIsaPkg::opJal: begin
            alu   = pcIn + immJ;
            taken = 1'b1;
        end
        rvIsaPkg::opJalr: begin
            alu   = r1 + immI;
            taken = 1'b1;
        end
        rvIsaPkg::opLui:   alu = r1 + r2;
        rvIsaPkg::opAuipc: alu = pcIn + {inst[31:12], 12'd0};
        default:           bad = 1'b1;
    endcase

    case (inst[6:0])
        rvIsaPkg::opLoad:                  r.wbValue = 32'd0; // no memory data
        rvIsaPkg::opJal, rvIsaPkg::opJalr: r.wbValue = pcIn + 32'd4;
        rvIsaPkg::opLui:                   r.wbValue = {inst[31:12], 12'd0};
        default:                           r.wbValue = alu;
    endcase

    target        = (inst[6:0] == rvIsaPkg::opJalr) ? {alu[31:1], 1'b0} : alu;
    r.memAddr     = alu;
    r.branchTaken = taken;
    r.nextPc      = taken ? target : pcIn + 32'd4;
    misaligned    = (r.memRead || r.memWrite) &&
                    ((r.memSize == rvIsaPkg::sizeHalf && alu[0]) ||
                     (r.memSize == rvIsaPkg::sizeWord && alu[1:0] != 2'b00));
    r.halt        = bad || misaligned || (taken && target[1:0] != 2'b00);
    r.regWrite    = wrt && !r.halt;
    return r;
endfunction

`endif

// File: tbRvExecSlice.sv
/* Testbench for the RV32I execute slice
   random instruction stimulus, reference queue and result compare */
`timescale 1ns/1ps

module tbRvExecSlice;

    localparam int nAlu     = 200;
    localparam int nMem     = 60;
    localparam int nBranch  = 80;
    localparam int nUpper   = 20;
    localparam int nIllegal = 30;
    localparam int nTests   = 6;
    localparam int nStrobes = 1 + nAlu + nMem + nBranch + nUpper + nIllegal;
    localparam int timeoutLimit = nStrobes + 3 * nTests + 50;

    logic                  clk;
    logic                  rstN;
    logic                  instValid;
    logic [31:0]           instWord;
    logic [31:0]           pc;
    logic [31:0]           rs1Data;
    logic [31:0]           rs2Data;
    logic                  resValid;
    rvPipePkg::execResultT result;

    rvPipePkg::execResultT expQ[$];
    int                    dueQ[$];
    rvPipePkg::execResultT expRes;
    int                    dueNow;
    int                    cycle = 0;
    int                    resCount = 0;
    int                    errCount = 0;
    int                    resMark;
    int                    errMark;
    logic [31:0]           rngState = 32'd89456;

    `include "tbRvModel.svh"

    rvExecSlice u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instWord  (instWord),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .resValid  (resValid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] randPc();
        logic [31:0] x;
        x = xorshift();
        return {x[31:2], 2'b00};
    endfunction

    task automatic checkField(input string name, input logic [31:0] expV,
                              input logic [31:0] actV);
        if (expV !== actV) begin
            errCount++;
            $display("error: %s expected %h got %h", name, expV, actV);
        end
    endtask

    task automatic compareResult(input rvPipePkg::execResultT e);
        checkField("result.rd", 32'(e.rd), 32'(result.rd));
        checkField("result.regWrite", 32'(e.regWrite), 32'(result.regWrite));
        checkField("result.wbValue", e.wbValue, result.wbValue);
        checkField("result.memRead", 32'(e.memRead), 32'(result.memRead));
        checkField("result.memWrite", 32'(e.memWrite), 32'(result.memWrite));
        checkField("result.memAddr", e.memAddr, result.memAddr);
        checkField("result.memSize", 32'(e.memSize), 32'(result.memSize));
        checkField("result.branchTaken", 32'(e.branchTaken), 32'(result.branchTaken));
        checkField("result.nextPc", e.nextPc, result.nextPc);
        checkField("result.halt", 32'(e.halt), 32'(result.halt));
    endtask

    // each result must land exactly 3 edges after its strobe was sampled
    always @(negedge clk) begin
        if (dueQ.size() != 0 && dueQ[0] == cycle) begin
            expRes = expQ.pop_front();
            dueNow = dueQ.pop_front();
            resCount++;
            if (resValid)
                compareResult(expRes);
            else begin
                errCount++;
                $display("result strobe missing at cycle %0d", dueNow);
            end
        end else if (resValid) begin
            errCount++;
            $display("unexpected result strobe at cycle %0d", cycle);
        end
    end

    // called 10 ns after a rising edge, returns 10 ns after the next one
    task automatic sendInst(input logic [31:0] word, input logic [31:0] pcVal,
                            input logic [31:0] r1, input logic [31:0] r2);
        instValid = 1'b1;
        instWord  = word;
        pc        = pcVal;
        rs1Data   = r1;
        rs2Data   = r2;
        expQ.push_back(rvExpect(word, pcVal, r1, r2));
        dueQ.push_back(cycle + 3);
        @(posedge clk);
        #10;
        instValid = 1'b0;
    endtask

    task automatic beginTest();
        resMark = resCount;
        errMark = errCount;
    endtask

    task automatic endTest(input string name);
        while (dueQ.size() != 0)
            @(posedge clk);
        #10;
        $display("test %s: %0d results, %0d errors", name, resCount - resMark,
                 errCount - errMark);
    endtask

    task automatic runResetTest();
        beginTest();
        repeat (5) @(posedge clk);
        #10;
        if (resValid !== 1'b0) begin
            errCount++;
            $display("resValid is high after reset with no instruction sent");
        end
        sendInst({12'd5, 5'd0, 3'd0, 5'd1, rvIsaPkg::opICompute}, 32'h100, 32'h10, 32'h0);
        endTest("reset");
    endtask

    task automatic runAluTest();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] word;
        int          i;
        beginTest();
        for (i = 0; i < nAlu; i++) begin
            r  = xorshift();
            f3 = r[2:0];
            f7 = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? rvIsaPkg::funct7Alt : 7'h00;
            if (r[4])
                word = {f7, r[9:5], r[14:10], f3, r[19:15], rvIsaPkg::opCompute};
            else if (f3 == 3'd1 || f3 == 3'd5)
                word = {f7, r[24:20], r[14:10], f3, r[19:15], rvIsaPkg::opICompute};
            else
                word = {r[31:20], r[14:10], f3, r[19:15], rvIsaPkg::opICompute};
            sendInst(word, randPc(), xorshift(), xorshift());
        end
        endTest("alu");
    endtask

    task automatic runMemTest();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [31:0] word;
        int          i;
        beginTest();
        for (i = 0; i < nMem; i++) begin
            r = xorshift();
            if (r[5]) begin
                case (r[2:0])
                    3'd0:    f3 = 3'd0;
                    3'd1:    f3 = 3'd1;
                    3'd3:    f3 = 3'd4;
                    3'd4:    f3 = 3'd5;
                    default: f3 = 3'd2;
                endcase
                word = {r[31:20], r[19:15], f3, r[11:7], rvIsaPkg::opLoad};
            end else begin
                f3   = (r[1:0] == 2'd3) ? 3'd2 : {1'b0, r[1:0]};
                word = {r[31:25], r[24:20], r[19:15], f3, r[11:7], rvIsaPkg::opStore};
            end
            sendInst(word, randPc(), xorshift(), xorshift());
        end
        endTest("load/store");
    endtask

    task automatic runBranchTest();
        logic [31:0] r;
        logic [31:0] r1;
        logic [2:0]  f3;
        logic [12:0] immB;
        logic [20:0] immJ;
        logic [31:0] word;
        int          i;
        int          k;
        beginTest();
        for (i = 0; i < nBranch; i++) begin
            r    = xorshift();
            r1   = xorshift();
            k    = i % 8;
            immB = {r[31:21], r[6] & r[7], 1'b0}; // bit 1 set now and then
            immJ = {r[31:13], r[6] & r[7], 1'b0};
            if (k < 6) begin
                f3   = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
                word = {immB[12], immB[10:5], r[16:12], r[11:7], f3, immB[4:1], immB[11],
                        rvIsaPkg::opBranch};
            end else if (k == 6)
                word = {immJ[20], immJ[10:1], immJ[11], immJ[19:12], r[11:7], rvIsaPkg::opJal};
            else
                word = {r[31:20], r[16:12], 3'd0, r[11:7], rvIsaPkg::opJalr};
            sendInst(word, randPc(), r1, r[5] ? r1 : xorshift());
        end
        endTest("branch/jump");
    endtask

    task automatic runUpperTest();
        logic [31:0] r;
        int          i;
        beginTest();
        for (i = 0; i < nUpper; i++) begin
            r = xorshift();
            sendInst({r[31:7], r[0] ? rvIsaPkg::opLui : rvIsaPkg::opAuipc}, randPc(),
                     xorshift(), xorshift());
        end
        endTest("lui/auipc");
    endtask

    task automatic runIllegalTest();
        logic [31:0] r;
        logic [6:0]  badOp;
        logic [31:0] word;
        int          i;
        beginTest();
        for (i = 0; i < nIllegal; i++) begin
            r = xorshift();
            case (r[1:0])
                2'd0:    badOp = 7'h0b;
                2'd1:    badOp = 7'h2b;
                2'd2:    badOp = 7'h5b;
                default: badOp = 7'h7b;
            endcase
            case (i % 6)
                0:       word = {r[31:7], badOp};
                1:       word = {7'h40, r[24:7], rvIsaPkg::opCompute};
                2:       word = {7'h01, r[24:7], rvIsaPkg::opCompute}; // multiply space
                3:       word = {r[31:15], r[2] ? {2'b11, r[3]} : 3'd3, r[11:7],
                                 rvIsaPkg::opLoad};
                4:       word = {r[31:15], r[2] ? {1'b1, r[4:3]} : 3'd3, r[11:7],
                                 rvIsaPkg::opStore};
                default: word = {r[31:15], 2'b01, r[3], r[11:7], rvIsaPkg::opBranch};
            endcase
            sendInst(word, randPc(), xorshift(), xorshift());
        end
        endTest("illegal");
    endtask

    initial begin
        wait (cycle >= timeoutLimit);
        $display("timeout after %0d cycles with results still pending", cycle);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rstN      = 1'b0;
        instValid = 1'b0;
        instWord  = '0;
        pc        = '0;
        rs1Data   = '0;
        rs2Data   = '0;
        repeat (3) @(posedge clk);
        #10;
        rstN = 1'b1;
        runResetTest();
        runAluTest();
        runMemTest();
        runBranchTest();
        runUpperTest();
        runIllegalTest();
        $display("results %0d, errors %0d", resCount, errCount);
        if (errCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
